//--- include/nic_switch_params.svh
// ==========================================================
// Global sizes and register map of the loopback NIC switch
// Included by the package and by every block that sizes
// ports or decodes Wishbone addresses
// ==========================================================

`ifndef NIC_SWITCH_PARAMS_SVH
`define NIC_SWITCH_PARAMS_SVH

// Fabric dimensions
`define NUM_PORTS 4
`define PORT_ID_W 2
`define DATA_W    64
`define CNT_W     16

// Host register bus
`define WB_ADDR_W 8
`define WB_DATA_W 32

// Register map, word addresses
`define REG_ENABLE        8'h00
`define REG_CLEAR         8'h01
`define REG_TX_CNT_BASE   8'h10
`define REG_RX_CNT_BASE   8'h20
`define REG_DROP_CNT_BASE 8'h30

`endif

//--- design/nic_switch_pkg.sv
// ==========================================================
// Shared types of the loopback NIC switch
// Import with nic_switch_pkg::* in any module or testbench
// that carries frames, counters or register bus signals
// ==========================================================

`include "nic_switch_params.svh"

package nic_switch_pkg;

    // Port addressing
    typedef logic [`PORT_ID_W-1:0] port_id_t;
    typedef logic [`NUM_PORTS-1:0] port_mask_t;

    // Frame payload, single beat
    typedef logic [`DATA_W-1:0] net_data_t;

    // Per-port statistics
    typedef logic [`CNT_W-1:0] pkt_cnt_t;

    // Wishbone classic slave
    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [`WB_DATA_W-1:0] wb_data_t;

    // Register block FSM
    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_t;

endpackage

//--- design/nic_csr_block.sv
// ==========================================================
// Host register block on a Wishbone classic slave
// Holds the port enable mask, pulses the counter clear and
// returns per-port statistics; each access gets one ack
// ==========================================================

`include "nic_switch_params.svh"

module nic_csr_block import nic_switch_pkg::*; (
    input  logic                         ccip_clk,
    input  logic                         network_rst,

    // Wishbone slave
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  wb_addr_t                     wb_adr,
    input  wb_data_t                     wb_dat_w,
    output logic                         wb_ack,
    output wb_data_t                     wb_dat_r,

    // Statistics from the ports
    input  pkt_cnt_t [`NUM_PORTS-1:0]    tx_cnt,
    input  pkt_cnt_t [`NUM_PORTS-1:0]    rx_cnt,
    input  pkt_cnt_t [`NUM_PORTS-1:0]    drop_cnt,

    // Control to the ports
    output port_mask_t                   port_enable,
    output logic                         counter_clear
);

    wb_state_t state;
    logic      req;
    wb_data_t  rd_mux;

    // New request is only taken in idle, so ack is low here
    assign req    = wb_cyc && wb_stb && (state == WB_IDLE);
    assign wb_ack = (state == WB_ACK);

    // ==========================================================
    // Read mux by address range
    // ==========================================================
    always_comb begin
        rd_mux = '0;
        if (wb_adr == `REG_ENABLE) begin
            rd_mux = wb_data_t'(port_enable);
        end
        for (int i = 0; i < `NUM_PORTS; i++) begin
            if (wb_adr == wb_addr_t'(`REG_TX_CNT_BASE + i)) begin
                rd_mux = wb_data_t'(tx_cnt[i]);
            end
            if (wb_adr == wb_addr_t'(`REG_RX_CNT_BASE + i)) begin
                rd_mux = wb_data_t'(rx_cnt[i]);
            end
            if (wb_adr == wb_addr_t'(`REG_DROP_CNT_BASE + i)) begin
                rd_mux = wb_data_t'(drop_cnt[i]);
            end
        end
    end

    // ==========================================================
    // Bus FSM and write decode
    // ==========================================================
    always_ff @(posedge ccip_clk) begin
        // Clear is a single-cycle command
        counter_clear <= 1'b0;

        case (state)
            WB_IDLE: begin
                if (req) begin
                    state <= WB_ACK;
                    if (wb_we && (wb_adr == `REG_ENABLE)) begin
                        port_enable <= wb_dat_w[`NUM_PORTS-1:0];
                    end
                    if (wb_we && (wb_adr == `REG_CLEAR)) begin
                        counter_clear <= 1'b1;
                    end
                end
            end
            WB_ACK: begin
                state <= WB_IDLE;
            end
            default: begin
                state <= WB_IDLE;
            end
        endcase

        if (network_rst) begin
            state         <= WB_IDLE;
            port_enable   <= '1;
            counter_clear <= 1'b0;
        end
    end

    // Read data captured with the request, held through ack
    always_ff @(posedge ccip_clk) begin
        if (req) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

//--- design/nic_port.sv
// ==========================================================
// One network endpoint of the loopback switch
// Filters and buffers one transmit frame until the fabric
// grants it, registers deliveries and keeps three counters
// ==========================================================

`include "nic_switch_params.svh"

module nic_port import nic_switch_pkg::*; #(
    parameter int PORT_ID = 0
) (
    input  logic       ccip_clk,
    input  logic       network_rst,

    // Host transmit side
    input  logic       tx_valid,
    input  net_data_t  tx_data,
    input  port_id_t   tx_dest,
    output logic       tx_ready,

    // Control from the register block
    input  port_mask_t port_enable,
    input  logic       counter_clear,

    // Line toward the router
    output logic       line_valid,
    output net_data_t  line_data,
    output port_id_t   line_dest,
    input  logic       line_grant,

    // Delivery from the router
    input  logic       deliver_valid,
    input  net_data_t  deliver_data,
    input  port_id_t   deliver_src,

    // Host receive side, no back-pressure
    output logic       rx_valid,
    output net_data_t  rx_data,
    output port_id_t   rx_src,

    // Statistics
    output pkt_cnt_t   tx_cnt,
    output pkt_cnt_t   rx_cnt,
    output pkt_cnt_t   drop_cnt
);

    localparam port_id_t SELF_ID = port_id_t'(PORT_ID);

    logic      buf_valid;
    net_data_t buf_data;
    port_id_t  buf_dest;
    logic      accept;
    logic      drop;

    assign tx_ready = !buf_valid;
    assign accept   = tx_valid && tx_ready;

    // Sender off, loop to self, or receiver off
    assign drop = !port_enable[SELF_ID] || (tx_dest == SELF_ID) || !port_enable[tx_dest];

    assign line_valid = buf_valid;
    assign line_data  = buf_data;
    assign line_dest  = buf_dest;

    // ==========================================================
    // One-entry transmit buffer
    // ==========================================================
    always_ff @(posedge ccip_clk) begin
        if (network_rst) begin
            buf_valid <= 1'b0;
        end else if (accept && !drop) begin
            buf_valid <= 1'b1;
        end else if (line_grant) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (accept && !drop) begin
            buf_data <= tx_data;
            buf_dest <= tx_dest;
        end
    end

    // Receive register
    always_ff @(posedge ccip_clk) begin
        if (network_rst) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= deliver_valid;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (deliver_valid) begin
            rx_data <= deliver_data;
            rx_src  <= deliver_src;
        end
    end

    // ==========================================================
    // Statistics counters
    // ==========================================================
    always_ff @(posedge ccip_clk) begin
        if (network_rst || counter_clear) begin
            tx_cnt   <= '0;
            rx_cnt   <= '0;
            drop_cnt <= '0;
        end else begin
            if (line_grant) tx_cnt <= tx_cnt + 1'b1;
            if (deliver_valid) rx_cnt <= rx_cnt + 1'b1;
            if (accept && drop) drop_cnt <= drop_cnt + 1'b1;
        end
    end

endmodule

//--- design/loopback_router.sv
// ==========================================================
// Loopback fabric between the endpoints
// Each destination takes the lowest-index sender aiming at
// it; the winner is granted and delivered one cycle later
// ==========================================================

`include "nic_switch_params.svh"

module loopback_router import nic_switch_pkg::*; (
    input  logic                          ccip_clk,
    input  logic                          network_rst,

    // Sender lines
    input  port_mask_t                    line_valid,
    input  net_data_t [`NUM_PORTS-1:0]    line_data,
    input  port_id_t  [`NUM_PORTS-1:0]    line_dest,
    output port_mask_t                    line_grant,

    // Delivery lines, indexed by destination
    output port_mask_t                    deliver_valid,
    output net_data_t [`NUM_PORTS-1:0]    deliver_data,
    output port_id_t  [`NUM_PORTS-1:0]    deliver_src
);

    port_mask_t                   win_valid;
    port_id_t [`NUM_PORTS-1:0]    win_src;

    // ==========================================================
    // Fixed-priority choice per destination
    // ==========================================================
    always_comb begin
        line_grant = '0;
        win_valid  = '0;
        win_src    = '0;
        for (int d = 0; d < `NUM_PORTS; d++) begin
            // Walk from the top so the lowest index wins last
            for (int s = `NUM_PORTS - 1; s >= 0; s--) begin
                if (line_valid[s] && (line_dest[s] == port_id_t'(d))) begin
                    win_valid[d] = 1'b1;
                    win_src[d]   = port_id_t'(s);
                end
            end
            if (win_valid[d]) begin
                line_grant[win_src[d]] = 1'b1;
            end
        end
    end

    // ==========================================================
    // Registered delivery
    // ==========================================================
    always_ff @(posedge ccip_clk) begin
        if (network_rst) begin
            deliver_valid <= '0;
        end else begin
            deliver_valid <= win_valid;
        end
    end

    always_ff @(posedge ccip_clk) begin
        for (int d = 0; d < `NUM_PORTS; d++) begin
            if (win_valid[d]) begin
                deliver_data[d] <= line_data[win_src[d]];
                deliver_src[d]  <= win_src[d];
            end
        end
    end

endmodule

//--- design/nic_switch_top.sv
// ==========================================================
// Top level of the loopback NIC switch
// Register block on Wishbone, one endpoint per port and the
// router that connects their lines
// ==========================================================

`include "nic_switch_params.svh"

module nic_switch_top import nic_switch_pkg::*; (
    input  logic                          ccip_clk,
    input  logic                          network_rst,

    // Wishbone slave
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  wb_addr_t                      wb_adr,
    input  wb_data_t                      wb_dat_w,
    output logic                          wb_ack,
    output wb_data_t                      wb_dat_r,

    // Per-port transmit
    input  port_mask_t                    tx_valid,
    input  net_data_t [`NUM_PORTS-1:0]    tx_data,
    input  port_id_t  [`NUM_PORTS-1:0]    tx_dest,
    output port_mask_t                    tx_ready,

    // Per-port receive
    output port_mask_t                    rx_valid,
    output net_data_t [`NUM_PORTS-1:0]    rx_data,
    output port_id_t  [`NUM_PORTS-1:0]    rx_src
);

    port_mask_t                   port_enable;
    logic                         counter_clear;
    pkt_cnt_t  [`NUM_PORTS-1:0]   tx_cnt;
    pkt_cnt_t  [`NUM_PORTS-1:0]   rx_cnt;
    pkt_cnt_t  [`NUM_PORTS-1:0]   drop_cnt;

    // Router links
    port_mask_t                   line_valid;
    net_data_t [`NUM_PORTS-1:0]   line_data;
    port_id_t  [`NUM_PORTS-1:0]   line_dest;
    port_mask_t                   line_grant;
    port_mask_t                   deliver_valid;
    net_data_t [`NUM_PORTS-1:0]   deliver_data;
    port_id_t  [`NUM_PORTS-1:0]   deliver_src;

    nic_csr_block u_nic_csr_block (
        .ccip_clk      (ccip_clk),
        .network_rst   (network_rst),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_ack        (wb_ack),
        .wb_dat_r      (wb_dat_r),
        .tx_cnt        (tx_cnt),
        .rx_cnt        (rx_cnt),
        .drop_cnt      (drop_cnt),
        .port_enable   (port_enable),
        .counter_clear (counter_clear)
    );

    // ==========================================================
    // Endpoints, id taken from the loop index
    // ==========================================================
    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
        nic_port #(
            .PORT_ID (i)
        ) u_nic_port (
            .ccip_clk      (ccip_clk),
            .network_rst   (network_rst),
            .tx_valid      (tx_valid[i]),
            .tx_data       (tx_data[i]),
            .tx_dest       (tx_dest[i]),
            .tx_ready      (tx_ready[i]),
            .port_enable   (port_enable),
            .counter_clear (counter_clear),
            .line_valid    (line_valid[i]),
            .line_data     (line_data[i]),
            .line_dest     (line_dest[i]),
            .line_grant    (line_grant[i]),
            .deliver_valid (deliver_valid[i]),
            .deliver_data  (deliver_data[i]),
            .deliver_src   (deliver_src[i]),
            .rx_valid      (rx_valid[i]),
            .rx_data       (rx_data[i]),
            .rx_src        (rx_src[i]),
            .tx_cnt        (tx_cnt[i]),
            .rx_cnt        (rx_cnt[i]),
            .drop_cnt      (drop_cnt[i])
        );
    end

    loopback_router u_loopback_router (
        .ccip_clk      (ccip_clk),
        .network_rst   (network_rst),
        .line_valid    (line_valid),
        .line_data     (line_data),
        .line_dest     (line_dest),
        .line_grant    (line_grant),
        .deliver_valid (deliver_valid),
        .deliver_data  (deliver_data),
        .deliver_src   (deliver_src)
    );

endmodule

//--- dv/nic_switch_checker.sv
// ==========================================================
// Protocol assertions for the loopback NIC switch
// Bound to the top level; counts its own failures
// ==========================================================

`include "nic_switch_params.svh"

module nic_switch_checker import nic_switch_pkg::*; (
    input logic       ccip_clk,
    input logic       network_rst,
    input logic       wb_cyc,
    input logic       wb_ack,
    input port_mask_t rx_valid,
    input port_mask_t line_valid,
    input port_mask_t line_grant
);

    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    // One ack per access
    a_ack_single: assert property (@(posedge ccip_clk) disable iff (network_rst)
        wb_ack |=> !wb_ack)
        else begin
            $error("wishbone ack high for two cycles");
            failures++;
        end

    a_ack_in_cycle: assert property (@(posedge ccip_clk) disable iff (network_rst)
        wb_ack |-> wb_cyc)
        else begin
            $error("wishbone ack outside a bus cycle");
            failures++;
        end

    a_rx_reset: assert property (@(posedge ccip_clk) network_rst |=> (rx_valid == '0))
        else begin
            $error("rx_valid high during reset");
            failures++;
        end

    // A buffered frame leaves only through a grant
    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_line
        a_line_hold: assert property (@(posedge ccip_clk) disable iff (network_rst)
            (line_valid[i] && !line_grant[i]) |=> line_valid[i])
            else begin
                $error("line_valid of port %0d fell without a grant", i);
                failures++;
            end
    end

endmodule

//--- dv/nic_switch_tb.sv
// ==========================================================
// Testbench of the loopback NIC switch
// Drives random frames from a fixed seed, checks deliveries
// against a per-pair queue model and reads the statistics
// and enable mask back over Wishbone
// ==========================================================

`include "nic_switch_params.svh"

module nic_switch_tb import nic_switch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MODE_NO_SELF = 0;
    localparam int MODE_ANY     = 1;
    localparam int MODE_HOT     = 2;
    localparam int TOTAL_FRAMES = 400 + 4 * 20 + 4 * 4 * 25;
    // Worst case of 16 cycles per frame plus register accesses
    localparam longint WATCHDOG_NS = (TOTAL_FRAMES * 16 + 1000) * 20;

    logic                          ccip_clk;
    logic                          network_rst;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    wb_addr_t                      wb_adr;
    wb_data_t                      wb_dat_w;
    logic                          wb_ack;
    wb_data_t                      wb_dat_r;
    port_mask_t                    tx_valid;
    net_data_t [`NUM_PORTS-1:0]    tx_data;
    port_id_t  [`NUM_PORTS-1:0]    tx_dest;
    port_mask_t                    tx_ready;
    port_mask_t                    rx_valid;
    net_data_t [`NUM_PORTS-1:0]    rx_data;
    port_id_t  [`NUM_PORTS-1:0]    rx_src;

    // Model state, one queue per source and destination
    net_data_t  model_q [`NUM_PORTS][`NUM_PORTS][$];
    pkt_cnt_t   model_tx [`NUM_PORTS];
    pkt_cnt_t   model_rx [`NUM_PORTS];
    pkt_cnt_t   model_drop [`NUM_PORTS];
    port_mask_t model_mask;

    nic_switch_top u_nic_switch_top (
        .ccip_clk    (ccip_clk),
        .network_rst (network_rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_dest     (tx_dest),
        .tx_ready    (tx_ready),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_src      (rx_src)
    );

    bind nic_switch_top nic_switch_checker u_nic_switch_checker (
        .ccip_clk    (ccip_clk),
        .network_rst (network_rst),
        .wb_cyc      (wb_cyc),
        .wb_ack      (wb_ack),
        .rx_valid    (rx_valid),
        .line_valid  (line_valid),
        .line_grant  (line_grant)
    );

    always #10 ccip_clk = ~ccip_clk;

    // ==========================================================
    // Failure reporting and compare tasks
    // ==========================================================
    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_data(string name, net_data_t got, net_data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error: time %0t, signal %s, got %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_src(string name, port_id_t got, port_id_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error: time %0t, signal %s, got %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_cnt(string name, pkt_cnt_t got, pkt_cnt_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error: time %0t, signal %s, got %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_mask(string name, port_mask_t got, port_mask_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error: time %0t, signal %s, got %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    // ==========================================================
    // Wishbone master, called 2 ns after a rising edge
    // ==========================================================
    task automatic wb_access(logic we, wb_addr_t adr, wb_data_t wdata, output wb_data_t rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge ccip_clk);
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge ccip_clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge ccip_clk);
        if (wb_ack) begin
            stop_on_error("wishbone ack stayed high for a second cycle");
        end
        @(posedge ccip_clk);
        #2;
    endtask

    task automatic check_stats();
        wb_data_t rd;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            wb_access(1'b0, wb_addr_t'(`REG_TX_CNT_BASE + p), '0, rd);
            check_cnt($sformatf("tx_cnt[%0d]", p), pkt_cnt_t'(rd), model_tx[p]);
            wb_access(1'b0, wb_addr_t'(`REG_RX_CNT_BASE + p), '0, rd);
            check_cnt($sformatf("rx_cnt[%0d]", p), pkt_cnt_t'(rd), model_rx[p]);
            wb_access(1'b0, wb_addr_t'(`REG_DROP_CNT_BASE + p), '0, rd);
            check_cnt($sformatf("drop_cnt[%0d]", p), pkt_cnt_t'(rd), model_drop[p]);
        end
    endtask

    // ==========================================================
    // Frame stimulus and model
    // ==========================================================
    task automatic model_accept(int src, port_id_t dst, net_data_t data);
        if (!model_mask[src] || dst == port_id_t'(src) || !model_mask[dst]) begin
            model_drop[src]++;
        end else begin
            model_q[src][dst].push_back(data);
            model_tx[src]++;
        end
    endtask

    task automatic send_frame(int src, port_id_t dst, net_data_t data);
        tx_valid[src] = 1'b1;
        tx_data[src]  = data;
        tx_dest[src]  = dst;
        do begin
            @(negedge ccip_clk);
        end while (!tx_ready[src]);
        // Ready seen here means the next edge accepts
        model_accept(src, dst, data);
        @(posedge ccip_clk);
        #2;
        tx_valid[src] = 1'b0;
    endtask

    task automatic port_traffic(int src, int n, int mode);
        port_id_t dst;
        @(posedge ccip_clk);
        #2;
        for (int i = 0; i < n; i++) begin
            if (mode == MODE_ANY) begin
                dst = port_id_t'($urandom_range(`NUM_PORTS - 1));
            end else if (mode == MODE_HOT) begin
                dst = (src == 0) ? port_id_t'(1) : port_id_t'(0);
            end else begin
                dst = port_id_t'((src + 1 + $urandom_range(`NUM_PORTS - 2)) % `NUM_PORTS);
            end
            send_frame(src, dst, {$urandom, $urandom});
            if ($urandom_range(3) == 0) begin
                @(posedge ccip_clk);
                #2;
            end
        end
    endtask

    task automatic run_traffic(int n, int mode);
        for (int p = 0; p < `NUM_PORTS; p++) begin
            automatic int src = p;
            fork
                port_traffic(src, n, mode);
            join_none
        end
        wait fork;
    endtask

    function automatic int frames_pending();
        int total;
        total = 0;
        for (int s = 0; s < `NUM_PORTS; s++) begin
            for (int d = 0; d < `NUM_PORTS; d++) begin
                total += model_q[s][d].size();
            end
        end
        return total;
    endfunction

    task automatic wait_drain();
        while (frames_pending() != 0) begin
            @(negedge ccip_clk);
        end
        @(posedge ccip_clk);
        #2;
    endtask

    // The payload names its sender among the oldest frames queued for this port
    task automatic check_arrival(int dst);
        port_id_t got_src;
        port_id_t owner;
        logic     owned;
        got_src = rx_src[dst];
        owner   = '0;
        owned   = 1'b0;
        for (int s = 0; s < `NUM_PORTS; s++) begin
            if (!owned && model_q[s][dst].size() != 0) begin
                if (model_q[s][dst][0] == rx_data[dst]) begin
                    owned = 1'b1;
                    owner = port_id_t'(s);
                end
            end
        end
        if (owned) begin
            check_src($sformatf("rx_src[%0d]", dst), got_src, owner);
            model_q[owner][dst].delete(0);
            model_rx[dst]++;
        end else if (model_q[got_src][dst].size() != 0) begin
            check_data($sformatf("rx_data[%0d]", dst), rx_data[dst],
                       model_q[got_src][dst][0]);
        end else begin
            stop_on_error($sformatf("port %0d received a frame that was never expected", dst));
        end
    endtask

    always @(negedge ccip_clk) begin
        if (u_nic_switch_top.u_nic_switch_checker.failures != 0) begin
            stop_on_error("the protocol checker reported an assertion failure");
        end
        if (!network_rst) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (rx_valid[p]) begin
                    check_arrival(p);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("watchdog expired before the traffic finished");
    end

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        wb_data_t   rd;
        port_mask_t mask;
        void'($urandom(76));
        ccip_clk    = 1'b0;
        network_rst = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        tx_valid    = '0;
        tx_data     = '0;
        tx_dest     = '0;
        model_mask  = '1;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            model_tx[p]   = '0;
            model_rx[p]   = '0;
            model_drop[p] = '0;
        end
        repeat (4) @(posedge ccip_clk);
        #2;
        network_rst = 1'b0;

        // Enable mask reset value and read back
        wb_access(1'b0, `REG_ENABLE, '0, rd);
        check_mask("port_enable", port_mask_t'(rd), '1);
        wb_access(1'b1, `REG_ENABLE, 32'h5, rd);
        wb_access(1'b0, `REG_ENABLE, '0, rd);
        check_mask("port_enable", port_mask_t'(rd), port_mask_t'(5));
        wb_access(1'b1, `REG_ENABLE, '1, rd);

        run_traffic(100, MODE_NO_SELF);
        wait_drain();
        run_traffic(20, MODE_HOT);
        wait_drain();

        // Random masks with self-destinations allowed
        repeat (4) begin
            mask = port_mask_t'($urandom);
            wb_access(1'b1, `REG_ENABLE, wb_data_t'(mask), rd);
            model_mask = mask;
            run_traffic(25, MODE_ANY);
            wait_drain();
        end
        wb_access(1'b1, `REG_ENABLE, '1, rd);
        model_mask = '1;
        check_stats();

        wb_access(1'b1, `REG_CLEAR, '0, rd);
        for (int p = 0; p < `NUM_PORTS; p++) begin
            model_tx[p]   = '0;
            model_rx[p]   = '0;
            model_drop[p] = '0;
        end
        check_stats();

        if (u_nic_switch_top.u_nic_switch_checker.failures != 0) begin
            stop_on_error("the protocol checker reported assertion failures");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- sources.f
+incdir+include
design/nic_switch_pkg.sv
design/nic_csr_block.sv
design/nic_port.sv
design/loopback_router.sv
design/nic_switch_top.sv
dv/nic_switch_checker.sv
dv/nic_switch_tb.sv

//--- Bender.yml
package:
  name: nic_switch

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/nic_switch_pkg.sv
      - design/nic_csr_block.sv
      - design/nic_port.sv
      - design/loopback_router.sv
      - design/nic_switch_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/nic_switch_checker.sv
      - dv/nic_switch_tb.sv
